/* all.f */
common/stripe_pkg.sv
lane_fifo/lane_fifo.sv
lane_fifo/lane_monitor.sv
hdl/stripe_dispatch.sv
hdl/stripe_collect.sv
hdl/stripe_buffer.sv
testbench/tb_stripe_buffer.sv

/* common/stripe_pkg.sv */
// Sizes, data types and lane status structs shared by the striped buffer RTL and its testbench
`default_nettype none

package stripe_pkg;

  // Geometry of the striped buffer
  localparam int LANES = 4;
  localparam int DEPTH = 8;
  localparam int WIDTH = 16;

  // Pointer width inside one lane FIFO
  localparam int PTR_W = $clog2(DEPTH);

  // Lane index, one of LANES
  typedef logic [$clog2(LANES)-1:0] lane_t;

  // Occupancy from 0 up to and including DEPTH
  typedef logic [$clog2(DEPTH+1)-1:0] occ_t;

  // Saturating event counter
  typedef logic [7:0] cnt_t;

  // One data word
  typedef logic [WIDTH-1:0] data_t;

  // Per-cycle FIFO status, levels and acceptance pulses
  typedef struct packed {
    logic empty;
    logic full;
    logic wr_ack;
    logic rd_ack;
  } fifo_flags_t;

  // Statistics of one lane as seen by its monitor
  typedef struct packed {
    occ_t occ;
    cnt_t ovf_cnt;
    cnt_t udf_cnt;
    logic flag_err;
  } lane_stat_t;

endpackage

`default_nettype wire

/* hdl/stripe_buffer.sv */
// Top level of the striped word buffer, joining dispatcher, lane FIFOs with monitors, and collector
`default_nettype none
`timescale 1ns/1ns

module stripe_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_push,
  input  stripe_pkg::data_t      in_data,
  output logic                   in_ready,
  input  logic                   out_pop,
  output logic                   out_empty,
  output logic                   out_valid,
  output stripe_pkg::data_t      out_data,
  output stripe_pkg::lane_stat_t lane_stat [stripe_pkg::LANES]
);

  logic [stripe_pkg::LANES-1:0] wr_en;
  logic [stripe_pkg::LANES-1:0] rd_en;
  logic [stripe_pkg::LANES-1:0] lane_dout_valid;
  stripe_pkg::data_t            wr_data;
  stripe_pkg::data_t            lane_dout [stripe_pkg::LANES];
  stripe_pkg::fifo_flags_t      lane_flags [stripe_pkg::LANES];

  stripe_dispatch u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .in_push    (in_push),
    .in_data    (in_data),
    .lane_flags (lane_flags),
    .in_ready   (in_ready),
    .wr_en      (wr_en),
    .wr_data    (wr_data)
  );

  // One FIFO and its monitor per lane
  for (genvar g = 0; g < stripe_pkg::LANES; g++) begin : g_lane
    lane_fifo u_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_en      (wr_en[g]),
      .wr_data    (wr_data),
      .rd_en      (rd_en[g]),
      .flags      (lane_flags[g]),
      .dout       (lane_dout[g]),
      .dout_valid (lane_dout_valid[g])
    );

    lane_monitor u_monitor (
      .clk   (clk),
      .rst   (rst),
      .wr_en (wr_en[g]),
      .rd_en (rd_en[g]),
      .flags (lane_flags[g]),
      .stat  (lane_stat[g])
    );
  end

  stripe_collect u_collect (
    .clk             (clk),
    .rst             (rst),
    .out_pop         (out_pop),
    .lane_flags      (lane_flags),
    .lane_dout       (lane_dout),
    .lane_dout_valid (lane_dout_valid),
    .rd_en           (rd_en),
    .out_empty       (out_empty),
    .out_valid       (out_valid),
    .out_data        (out_data)
  );

endmodule

`default_nettype wire

/* hdl/stripe_collect.sv */
// Read side of the striped buffer, pops the lanes in round-robin order and muxes their data out
`default_nettype none
`timescale 1ns/1ns

module stripe_collect (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          out_pop,
  input  stripe_pkg::fifo_flags_t       lane_flags [stripe_pkg::LANES],
  input  stripe_pkg::data_t             lane_dout [stripe_pkg::LANES],
  input  logic [stripe_pkg::LANES-1:0]  lane_dout_valid,
  output logic [stripe_pkg::LANES-1:0]  rd_en,
  output logic                          out_empty,
  output logic                          out_valid,
  output stripe_pkg::data_t             out_data
);

  stripe_pkg::lane_t rd_ptr;
  stripe_pkg::lane_t last_lane;
  logic              sel_ack;

  // The head word always sits in the lane at the read pointer
  assign out_empty = lane_flags[rd_ptr].empty;
  assign sel_ack   = lane_flags[rd_ptr].rd_ack;

  always_comb begin
    for (int i = 0; i < stripe_pkg::LANES; i++) begin
      rd_en[i] = out_pop && (rd_ptr == stripe_pkg::lane_t'(i));
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr    <= '0;
      last_lane <= '0;
    end else if (sel_ack) begin
      // Remember the source lane for next cycle's output mux
      last_lane <= rd_ptr;
      if (rd_ptr == stripe_pkg::lane_t'(stripe_pkg::LANES - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Registered lane data appears one cycle after the pop
  assign out_valid = lane_dout_valid[last_lane];
  assign out_data  = lane_dout[last_lane];

endmodule

`default_nettype wire

/* hdl/stripe_dispatch.sv */
// Write side of the striped buffer, deals incoming words to the lanes in round-robin order
`default_nettype none
`timescale 1ns/1ns

module stripe_dispatch (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_push,
  input  stripe_pkg::data_t             in_data,
  input  stripe_pkg::fifo_flags_t       lane_flags [stripe_pkg::LANES],
  output logic                          in_ready,
  output logic [stripe_pkg::LANES-1:0]  wr_en,
  output stripe_pkg::data_t             wr_data
);

  stripe_pkg::lane_t wr_ptr;
  logic              sel_ack;

  // Status of the lane currently taking writes
  assign in_ready = !lane_flags[wr_ptr].full;
  assign sel_ack  = lane_flags[wr_ptr].wr_ack;

  // Only the selected lane sees the push strobe
  always_comb begin
    for (int i = 0; i < stripe_pkg::LANES; i++) begin
      wr_en[i] = in_push && (wr_ptr == stripe_pkg::lane_t'(i));
    end
  end

  // Data goes to every lane, the strobe picks the one that stores it
  assign wr_data = in_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (sel_ack) begin
      if (wr_ptr == stripe_pkg::lane_t'(stripe_pkg::LANES - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* lane_fifo/lane_fifo.sv */
// Single-lane synchronous FIFO with registered read data, instantiated once per lane
`default_nettype none
`timescale 1ns/1ns

module lane_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  stripe_pkg::data_t       wr_data,
  input  logic                    rd_en,
  output stripe_pkg::fifo_flags_t flags,
  output stripe_pkg::data_t       dout,
  output logic                    dout_valid
);

  typedef logic [stripe_pkg::PTR_W-1:0] ptr_t;

  stripe_pkg::data_t mem [stripe_pkg::DEPTH];
  ptr_t              wr_ptr;
  ptr_t              rd_ptr;
  stripe_pkg::occ_t  count;
  logic              empty;
  logic              full;
  logic              wr_ok;
  logic              rd_ok;

  // Circular increment, wraps after the last entry
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(stripe_pkg::DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == stripe_pkg::occ_t'(stripe_pkg::DEPTH));

  // Accept unless blocked by the matching flag
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  assign flags.empty  = empty;
  assign flags.full   = full;
  assign flags.wr_ack = wr_ok;
  assign flags.rd_ack = rd_ok;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= rd_ok;
      if (wr_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* lane_fifo/lane_monitor.sv */
// Per-lane checker that rebuilds occupancy, counts blocked requests and flags FIFO status errors
`default_nettype none
`timescale 1ns/1ns

module lane_monitor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  logic                    rd_en,
  input  stripe_pkg::fifo_flags_t flags,
  output stripe_pkg::lane_stat_t  stat
);

  stripe_pkg::occ_t occ;
  stripe_pkg::cnt_t ovf_cnt;
  stripe_pkg::cnt_t udf_cnt;
  logic             flag_err;
  logic             wr_blocked;
  logic             rd_blocked;
  logic             mismatch;

  // Requests the FIFO refused this cycle
  assign wr_blocked = wr_en && !flags.wr_ack;
  assign rd_blocked = rd_en && !flags.rd_ack;

  // FIFO levels must agree with the occupancy rebuilt here
  assign mismatch = (flags.empty != (occ == '0)) ||
                    (flags.full != (occ == stripe_pkg::occ_t'(stripe_pkg::DEPTH)));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      occ      <= '0;
      ovf_cnt  <= '0;
      udf_cnt  <= '0;
      flag_err <= 1'b0;
    end else begin
      case ({flags.wr_ack, flags.rd_ack})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase

      // Counters stick at their maximum
      if (wr_blocked && (ovf_cnt != '1)) begin
        ovf_cnt <= ovf_cnt + 1'b1;
      end
      if (rd_blocked && (udf_cnt != '1)) begin
        udf_cnt <= udf_cnt + 1'b1;
      end

      // Sticky until reset
      if (mismatch) begin
        flag_err <= 1'b1;
      end
    end
  end

  assign stat.occ      = occ;
  assign stat.ovf_cnt  = ovf_cnt;
  assign stat.udf_cnt  = udf_cnt;
  assign stat.flag_err = flag_err;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the striped buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_stripe_buffer -f all.f -o sim_stripe_buffer
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_stripe_buffer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
  exit 0
fi
exit 1

/* testbench/tb_stripe_buffer.sv */
// Directed testbench for the striped word buffer that runs as simulation top against a reference queue
`default_nettype none
`timescale 1ns/1ns

module tb_stripe_buffer;

  localparam int LANES = stripe_pkg::LANES;
  localparam int DEPTH = stripe_pkg::DEPTH;
  // Reset, idle, streaming, fill and drain, empty pops, mixed traffic with drain, margin
  localparam int TEST_CYCLES = 10 + 4 + 41 + 68 + 5 + 200 + 33 + 8;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 10;

  logic                   clk;
  logic                   rst;
  logic                   in_push;
  stripe_pkg::data_t      in_data;
  logic                   in_ready;
  logic                   out_pop;
  logic                   out_empty;
  logic                   out_valid;
  stripe_pkg::data_t      out_data;
  stripe_pkg::lane_stat_t lane_stat [LANES];

  // Reference model state
  stripe_pkg::data_t ref_q [$];
  stripe_pkg::occ_t  occ_m [LANES];
  stripe_pkg::cnt_t  ovf_m [LANES];
  stripe_pkg::cnt_t  udf_m [LANES];
  stripe_pkg::lane_t wr_lane;
  stripe_pkg::lane_t rd_lane;
  integer            seed;
  int                errors;

  stripe_buffer DUT (
    .clk       (clk),
    .rst       (rst),
    .in_push   (in_push),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_pop   (out_pop),
    .out_empty (out_empty),
    .out_valid (out_valid),
    .out_data  (out_data),
    .lane_stat (lane_stat)
  );

  always #5 clk = ~clk;

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input stripe_pkg::data_t got,
                            input stripe_pkg::data_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_stat(input string name, input stripe_pkg::lane_stat_t got,
                            input stripe_pkg::lane_stat_t exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic stripe_pkg::lane_t next_lane(input stripe_pkg::lane_t l);
    return stripe_pkg::lane_t'((int'(l) + 1) % LANES);
  endfunction

  function automatic stripe_pkg::lane_stat_t model_stat(input int lane);
    stripe_pkg::lane_stat_t s;
    s.occ      = occ_m[lane];
    s.ovf_cnt  = ovf_m[lane];
    s.udf_cnt  = udf_m[lane];
    s.flag_err = 1'b0;
    return s;
  endfunction

  task automatic compare_all_stats();
    for (int i = 0; i < LANES; i++) begin
      check_stat($sformatf("lane_stat[%0d]", i), lane_stat[i], model_stat(i));
    end
  endtask

  // One clock cycle that starts and ends at a falling edge
  task automatic step(input logic push, input stripe_pkg::data_t data, input logic pop);
    logic              push_ok;
    logic              pop_ok;
    stripe_pkg::lane_t wl;
    stripe_pkg::lane_t rl;
    wl = wr_lane;
    rl = rd_lane;
    push_ok = push && (occ_m[wl] != stripe_pkg::occ_t'(DEPTH));
    pop_ok  = pop && (occ_m[rl] != '0);
    check_bit("in_ready", in_ready, occ_m[wl] != stripe_pkg::occ_t'(DEPTH));
    check_bit("out_empty", out_empty, occ_m[rl] == '0);
    in_push = push;
    in_data = data;
    out_pop = pop;
    @(negedge clk);
    // Read pops first so a same-lane write is never the word read
    if (pop_ok) begin
      occ_m[rl] = occ_m[rl] - 1'b1;
      rd_lane   = next_lane(rl);
      check_bit("out_valid", out_valid, 1'b1);
      check_data("out_data", out_data, ref_q.pop_front());
    end else begin
      check_bit("out_valid", out_valid, 1'b0);
      if (pop && udf_m[rl] != 8'hff) begin
        udf_m[rl] = udf_m[rl] + 1'b1;
      end
    end
    if (push_ok) begin
      ref_q.push_back(data);
      occ_m[wl] = occ_m[wl] + 1'b1;
      wr_lane   = next_lane(wl);
    end else if (push && ovf_m[wl] != 8'hff) begin
      ovf_m[wl] = ovf_m[wl] + 1'b1;
    end
    compare_all_stats();
  endtask

  task automatic drain();
    while (ref_q.size() > 0) begin
      step(1'b0, '0, 1'b1);
    end
    step(1'b0, '0, 1'b0);
  endtask

  task automatic idle_after_reset();
    repeat (4) step(1'b0, '0, 1'b0);
    for (int i = 0; i < LANES; i++) begin
      check_stat($sformatf("lane_stat[%0d]", i), lane_stat[i], '0);
    end
  endtask

  task automatic stream_in_order();
    stripe_pkg::lane_stat_t exp;
    for (int n = 0; n < 20; n++) begin
      step(1'b1, stripe_pkg::data_t'($random(seed)), 1'b0);
    end
    // Word n went to lane n mod LANES
    for (int i = 0; i < LANES; i++) begin
      exp = model_stat(i);
      exp.occ = stripe_pkg::occ_t'(20 / LANES + ((i < 20 % LANES) ? 1 : 0));
      check_stat($sformatf("lane_stat[%0d]", i), lane_stat[i], exp);
    end
    drain();
  endtask

  task automatic fill_and_overflow();
    stripe_pkg::lane_stat_t exp;
    for (int n = 0; n < LANES * DEPTH; n++) begin
      step(1'b1, stripe_pkg::data_t'($random(seed)), 1'b0);
    end
    check_bit("in_ready", in_ready, 1'b0);
    repeat (3) step(1'b1, stripe_pkg::data_t'($random(seed)), 1'b0);
    exp = '{occ: stripe_pkg::occ_t'(DEPTH), ovf_cnt: 8'd3, udf_cnt: udf_m[0], flag_err: 1'b0};
    check_stat("lane_stat[0]", lane_stat[0], exp);
    drain();
  endtask

  task automatic pop_while_empty();
    stripe_pkg::lane_stat_t exp;
    stripe_pkg::lane_t      lane;
    lane = rd_lane;
    repeat (5) step(1'b0, '0, 1'b1);
    exp = '{occ: '0, ovf_cnt: ovf_m[lane], udf_cnt: 8'd5, flag_err: 1'b0};
    check_stat($sformatf("lane_stat[%0d]", lane), lane_stat[lane], exp);
  endtask

  task automatic mixed_traffic();
    logic push;
    logic pop;
    for (int n = 0; n < 200; n++) begin
      push = (($random(seed) & 1) != 0);
      pop  = (($random(seed) & 1) != 0);
      step(push, stripe_pkg::data_t'($random(seed)), pop);
    end
    drain();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    in_push = 1'b0;
    in_data = '0;
    out_pop = 1'b0;
    seed    = 32'hd5b11bfe;
    errors  = 0;
    wr_lane = '0;
    rd_lane = '0;
    for (int i = 0; i < LANES; i++) begin
      occ_m[i] = '0;
      ovf_m[i] = '0;
      udf_m[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_after_reset();
    stream_in_order();
    fill_and_overflow();
    pop_while_empty();
    mixed_traffic();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
